/* Makefile */
TB_TOP := rv_exec_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module rv_exec_top

sim:
	verilator --binary --timing -j 0 -f project.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP)

clean:
	rm -rf obj_dir

/* bench/rv_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;

  import rv_pkg::*;

  localparam int N_RANDOM = 40;

  typedef struct {
    logic        valid;
    logic [31:0] pc;
    logic        illegal;
    logic        rd_we;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        is_branch;
    logic        taken;
    logic [31:0] next_pc;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
  } commit_t;

  logic        clk;
  logic        arst_n;
  logic        issue_valid;
  logic [31:0] issue_instruction;
  logic [31:0] issue_pc;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic        commit_illegal;
  logic        rd_we;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic        branch_taken;
  logic [31:0] next_pc;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;

  logic [31:0] model_regs [32];
  logic [31:0] tbl_inst [$];
  logic [31:0] tbl_pc [$];
  logic        tbl_gap [$];
  commit_t     exp_q [$];
  int          cycles = 0;
  int          limit;

  rv_exec_top dut0 (
    .clk              (clk),
    .arst_n           (arst_n),
    .issue_valid      (issue_valid),
    .issue_instruction(issue_instruction),
    .issue_pc         (issue_pc),
    .commit_valid     (commit_valid),
    .commit_pc        (commit_pc),
    .commit_illegal   (commit_illegal),
    .rd_we            (rd_we),
    .rd_addr          (rd_addr),
    .rd_data          (rd_data),
    .branch_taken     (branch_taken),
    .next_pc          (next_pc),
    .mem_req          (mem_req),
    .mem_we           (mem_we),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (arst_n) begin
      cycles = cycles + 1;
      if (cycles > limit) report_failure("Timeout: the run went past its cycle limit.");
    end
  end

  // ########################################
  // Reporting and compare tasks
  // ########################################

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic check_commit(input commit_t e);
    check_bit("commit_valid", commit_valid, e.valid);
    check_bit("commit_illegal", commit_illegal, e.illegal);
    check_bit("rd_we", rd_we, e.rd_we);
    check_bit("branch_taken", branch_taken, e.taken);
    check_bit("mem_req", mem_req, e.mem_req);
    check_bit("mem_we", mem_we, e.mem_we);
    if (e.valid) check_word("commit_pc", commit_pc, e.pc);
    if (e.rd_we) begin
      check_reg("rd_addr", rd_addr, e.rd_addr);
      check_word("rd_data", rd_data, e.rd_data);
    end
    if (e.is_branch) check_word("next_pc", next_pc, e.next_pc);
    if (e.mem_req) check_word("mem_addr", mem_addr, e.mem_addr);
    if (e.mem_we) check_word("mem_wdata", mem_wdata, e.mem_wdata);
  endtask

  // ########################################
  // Reference model
  // ########################################

  function automatic logic [31:0] arith_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = {31'b0, $signed(x) < $signed(y)};
      3'd3: r = {31'b0, x < y};
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt) r = $signed(x) >>> y[4:0];
        else r = x >> y[4:0];
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  function automatic commit_t predict(input logic [31:0] inst, input logic [31:0] pc);
    commit_t     c;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [2:0]  f3;
    logic        writes;
    c = '{default: '0};
    a = model_regs[inst[19:15]];
    b = model_regs[inst[24:20]];
    f3 = inst[14:12];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {inst[31:12], 12'h0};
    writes = 1'b1;
    c.valid = 1'b1;
    c.pc = pc;
    c.rd_addr = inst[11:7];
    case (inst[6:0])
      OPCODE_OP_IMM: c.rd_data = arith_model(f3, inst[30] && (f3 == 3'd5), a, imm_i);
      OPCODE_OP:     c.rd_data = arith_model(f3, inst[30], a, b);
      OPCODE_LUI:    c.rd_data = imm_u;
      OPCODE_AUIPC:  c.rd_data = pc + imm_u;
      OPCODE_LOAD: begin
        c.rd_data = a + imm_i; // Without data return rd gets the address.
        c.mem_req = 1'b1;
        c.mem_addr = a + imm_i;
      end
      OPCODE_STORE: begin
        writes = 1'b0;
        c.mem_req = 1'b1;
        c.mem_we = 1'b1;
        c.mem_addr = a + imm_s;
        c.mem_wdata = b;
      end
      OPCODE_BRANCH: begin
        writes = 1'b0;
        c.is_branch = 1'b1;
        case (f3)
          FUNCT3_BEQ:  c.taken = (a == b);
          FUNCT3_BNE:  c.taken = (a != b);
          FUNCT3_BLT:  c.taken = ($signed(a) < $signed(b));
          FUNCT3_BGE:  c.taken = ($signed(a) >= $signed(b));
          FUNCT3_BLTU: c.taken = (a < b);
          FUNCT3_BGEU: c.taken = (a >= b);
          default:     c.taken = 1'b0;
        endcase
        c.next_pc = c.taken ? pc + imm_b : pc + 32'd4;
      end
      default: begin
        writes = 1'b0;
        c.illegal = 1'b1;
      end
    endcase
    c.rd_we = writes && (c.rd_addr != 5'd0);
    return c;
  endfunction

  // ########################################
  // Encoders and stimulus
  // ########################################

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_entry(input logic [31:0] inst, input logic [31:0] pc, input logic gap);
    tbl_inst.push_back(inst);
    tbl_pc.push_back(pc);
    tbl_gap.push_back(gap);
  endtask

  task automatic build_table();
    add_entry(enc_u(OPCODE_LUI, 5'd1, 20'h80000), 32'h100, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd2, FUNCT3_ADDI, 5'd1, 12'hfff), 32'h104, 1'b0); // Bypass.
    add_entry(enc_i(OPCODE_OP_IMM, 5'd3, FUNCT3_ADDI, 5'd0, 12'hffb), 32'h108, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd4, FUNCT3_SLTI, 5'd3, 12'hffc), 32'h10c, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd5, FUNCT3_SLTIU, 5'd3, 12'h005), 32'h110, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd6, FUNCT3_XORI, 5'd2, 12'h0f0), 32'h114, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd7, FUNCT3_ORI, 5'd3, 12'h100), 32'h118, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd8, FUNCT3_ANDI, 5'd2, 12'h7ff), 32'h11c, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd9, FUNCT3_SLLI, 5'd3, 12'h004), 32'h120, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd10, FUNCT3_SRLI_SRAI, 5'd1, 12'h008), 32'h124, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd11, FUNCT3_SRLI_SRAI, 5'd1, 12'h408), 32'h128, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd0, FUNCT3_ADDI, 5'd2, 12'h001), 32'h12c, 1'b0); // x0.
    add_entry(enc_r(7'h00, 5'd3, 5'd0, FUNCT3_ADD_SUB, 5'd28), 32'h1fc, 1'b1); // Reads x0.
    // OP with operands from the register file.
    add_entry(enc_r(7'h20, 5'd2, 5'd3, FUNCT3_ADD_SUB, 5'd12), 32'h130, 1'b1);
    add_entry(enc_r(7'h20, 5'd9, 5'd1, FUNCT3_SRL_SRA, 5'd13), 32'h134, 1'b1);
    add_entry(enc_r(7'h00, 5'd2, 5'd3, FUNCT3_SLT, 5'd14), 32'h138, 1'b1);
    add_entry(enc_r(7'h00, 5'd2, 5'd3, FUNCT3_SLTU, 5'd15), 32'h13c, 1'b1);
    add_entry(enc_r(7'h00, 5'd13, 5'd12, FUNCT3_ADD_SUB, 5'd16), 32'h140, 1'b1);
    add_entry(enc_r(7'h00, 5'd3, 5'd1, FUNCT3_AND, 5'd17), 32'h144, 1'b1);
    add_entry(enc_r(7'h00, 5'd7, 5'd6, FUNCT3_OR, 5'd18), 32'h148, 1'b1);
    add_entry(enc_r(7'h00, 5'd8, 5'd6, FUNCT3_XOR, 5'd19), 32'h14c, 1'b1);
    add_entry(enc_r(7'h00, 5'd4, 5'd2, FUNCT3_SLL, 5'd20), 32'h150, 1'b1);
    add_entry(enc_r(7'h00, 5'd9, 5'd1, FUNCT3_SRL_SRA, 5'd26), 32'h154, 1'b1);
    // Dependent chain issued one per cycle.
    add_entry(enc_i(OPCODE_OP_IMM, 5'd21, FUNCT3_ADDI, 5'd0, 12'h007), 32'h158, 1'b0);
    add_entry(enc_r(7'h00, 5'd21, 5'd21, FUNCT3_ADD_SUB, 5'd22), 32'h15c, 1'b0);
    add_entry(enc_r(7'h20, 5'd21, 5'd22, FUNCT3_ADD_SUB, 5'd23), 32'h160, 1'b0);
    add_entry(enc_b(FUNCT3_BEQ, 5'd21, 5'd23, 13'h0010), 32'h164, 1'b0);
    add_entry(enc_b(FUNCT3_BEQ, 5'd21, 5'd22, 13'h0010), 32'h168, 1'b0);
    add_entry(enc_b(FUNCT3_BNE, 5'd21, 5'd22, 13'h1ff8), 32'h16c, 1'b0);
    add_entry(enc_b(FUNCT3_BNE, 5'd21, 5'd23, 13'h0010), 32'h170, 1'b0);
    add_entry(enc_b(FUNCT3_BLT, 5'd3, 5'd2, 13'h0020), 32'h174, 1'b0);
    add_entry(enc_b(FUNCT3_BLT, 5'd2, 5'd3, 13'h0020), 32'h178, 1'b0);
    add_entry(enc_b(FUNCT3_BGE, 5'd3, 5'd2, 13'h000c), 32'h17c, 1'b0);
    add_entry(enc_b(FUNCT3_BGE, 5'd2, 5'd3, 13'h000c), 32'h180, 1'b0);
    add_entry(enc_b(FUNCT3_BLTU, 5'd3, 5'd2, 13'h1f00), 32'h184, 1'b0);
    add_entry(enc_b(FUNCT3_BLTU, 5'd2, 5'd3, 13'h1f00), 32'h188, 1'b0);
    add_entry(enc_b(FUNCT3_BGEU, 5'd3, 5'd2, 13'h0ffe), 32'h18c, 1'b0);
    add_entry(enc_b(FUNCT3_BGEU, 5'd2, 5'd3, 13'h0ffe), 32'h190, 1'b0);
    // Memory, AUIPC and illegal words.
    add_entry(enc_i(OPCODE_LOAD, 5'd24, 3'b010, 5'd1, 12'h008), 32'h194, 1'b0);
    add_entry(enc_s(3'b010, 5'd1, 5'd2, 12'hffc), 32'h198, 1'b0);
    add_entry(enc_i(OPCODE_OP_IMM, 5'd27, FUNCT3_ADDI, 5'd28, 12'h055), 32'h19c, 1'b0);
    add_entry(enc_s(3'b010, 5'd21, 5'd27, 12'h010), 32'h1a0, 1'b0); // Store data bypass.
    add_entry(enc_u(OPCODE_AUIPC, 5'd25, 20'h00010), 32'h200, 1'b0);
    add_entry(32'h010000ef, 32'h204, 1'b0); // JAL is not supported.
    add_entry(32'hffffffff, 32'h208, 1'b0);
  endtask

  task automatic append_random();
    logic [31:0] rnd;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    rnd = 32'hdec2_5ae4;
    for (int k = 0; k < N_RANDOM; k++) begin
      rnd = next_random(rnd);
      f3 = rnd[3:1];
      if (rnd[0]) begin
        alt = rnd[19] && ((f3 == FUNCT3_ADD_SUB) || (f3 == FUNCT3_SRL_SRA));
        add_entry(enc_r({1'b0, alt, 5'b0}, rnd[18:14], rnd[13:9], f3, rnd[8:4]),
                  32'h400 + 32'(4 * k), 1'b0);
      end else begin
        if (f3 == FUNCT3_SLLI) imm = {7'b0, rnd[18:14]};
        else if (f3 == FUNCT3_SRLI_SRAI) imm = {1'b0, rnd[19], 5'b0, rnd[18:14]};
        else imm = rnd[31:20];
        add_entry(enc_i(OPCODE_OP_IMM, rnd[8:4], f3, rnd[13:9], imm),
                  32'h400 + 32'(4 * k), 1'b0);
      end
    end
  endtask

  // Checks the record issued two edges back and drives the next issue.
  task automatic step(input logic valid, input logic [31:0] inst, input logic [31:0] pc);
    commit_t c;
    @(negedge clk);
    if (exp_q.size() == 2) check_commit(exp_q.pop_front());
    issue_valid = valid;
    issue_instruction = inst;
    issue_pc = pc;
    if (valid) begin
      c = predict(inst, pc);
      if (c.rd_we) model_regs[c.rd_addr] = c.rd_data;
    end else begin
      c = '{default: '0};
    end
    exp_q.push_back(c);
  endtask

  initial begin
    arst_n = 1'b0;
    issue_valid = 1'b0;
    issue_instruction = 32'h0;
    issue_pc = 32'h0;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'h0;
    build_table();
    limit = tbl_inst.size() + N_RANDOM + 20;
    append_random();
    repeat (8) @(negedge clk);
    check_bit("commit_valid", commit_valid, 1'b0);
    arst_n = 1'b1;
    step(1'b0, 32'h0, 32'h0);
    step(1'b0, 32'h0, 32'h0);
    for (int i = 0; i < tbl_inst.size(); i++) begin
      step(1'b1, tbl_inst[i], tbl_pc[i]);
      if (tbl_gap[i]) step(1'b0, 32'h0, 32'h0);
    end
    step(1'b0, 32'h0, 32'h0); // Drain the pipeline.
    step(1'b0, 32'h0, 32'h0);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
rtl/rv_pkg.sv
rtl/exec_if.sv
rtl/imm_decode.sv
rtl/reg_file.sv
rtl/operand_fetch.sv
rtl/alu.sv
rtl/result_commit.sv
rtl/rv_exec_top.sv
bench/rv_exec_tb.sv

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  exec_if.dst         ex,
  output logic [31:0] result
);

  import rv_pkg::*;

  logic [31:0] i_imm;
  logic [31:0] s_imm;
  logic [31:0] u_imm;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [4:0]  shamt;
  logic        alt;
  logic [31:0] a;
  logic [31:0] b;

  imm_decode u_imm_decode (
    .inst (ex.instruction),
    .i_imm(i_imm),
    .s_imm(s_imm),
    .b_imm(),
    .u_imm(u_imm),
    .j_imm()
  );

  assign opcode = opcode_e'(ex.instruction[6:0]);
  assign funct3 = ex.instruction[14:12];
  assign shamt  = ex.instruction[24:20];
  assign alt    = ex.instruction[30]; // SUB and SRA select.
  assign a      = ex.op_a;
  assign b      = ex.op_b;

  always_comb begin
    result = 32'h0;
    case (opcode)
      OPCODE_OP_IMM: begin
        case (funct3)
          FUNCT3_ADDI:      result = a + i_imm;
          FUNCT3_SLTI:      result = {31'b0, $signed(a) < $signed(i_imm)};
          FUNCT3_SLTIU:     result = {31'b0, a < i_imm};
          FUNCT3_ANDI:      result = a & i_imm;
          FUNCT3_ORI:       result = a | i_imm;
          FUNCT3_XORI:      result = a ^ i_imm;
          FUNCT3_SLLI:      result = a << shamt;
          FUNCT3_SRLI_SRAI: result = alt ? $unsigned($signed(a) >>> shamt) : a >> shamt;
          default:          result = 32'h0;
        endcase
      end
      OPCODE_OP: begin
        case (funct3)
          FUNCT3_ADD_SUB: result = alt ? a - b : a + b;
          FUNCT3_SLT:     result = {31'b0, $signed(a) < $signed(b)};
          FUNCT3_SLTU:    result = {31'b0, a < b};
          FUNCT3_AND:     result = a & b;
          FUNCT3_OR:      result = a | b;
          FUNCT3_XOR:     result = a ^ b;
          FUNCT3_SLL:     result = a << b[4:0];
          FUNCT3_SRL_SRA: result = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
          default:        result = 32'h0;
        endcase
      end
      OPCODE_BRANCH: begin // Condition lands in bit 0.
        case (funct3)
          FUNCT3_BEQ:  result = {31'b0, a == b};
          FUNCT3_BNE:  result = {31'b0, a != b};
          FUNCT3_BLT:  result = {31'b0, $signed(a) < $signed(b)};
          FUNCT3_BGE:  result = {31'b0, $signed(a) >= $signed(b)};
          FUNCT3_BLTU: result = {31'b0, a < b};
          FUNCT3_BGEU: result = {31'b0, a >= b};
          default:     result = 32'h0;
        endcase
      end
      OPCODE_LUI:   result = u_imm;
      OPCODE_AUIPC: result = ex.pc + u_imm;
      OPCODE_LOAD:  result = a + i_imm;  // Effective address.
      OPCODE_STORE: result = a + s_imm;
      default:      result = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/exec_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Exec stage contents for one instruction and its operands.
interface exec_if;

  logic        valid;       // Stage holds an instruction.
  logic [31:0] instruction;
  logic [31:0] pc;
  logic [31:0] op_a;        // rs1 value after bypass.
  logic [31:0] op_b;        // rs2 value after bypass.

  modport src (
    output valid,
    output instruction,
    output pc,
    output op_a,
    output op_b
  );

  modport dst (
    input valid,
    input instruction,
    input pc,
    input op_a,
    input op_b
  );

endinterface

`default_nettype wire

/* rtl/imm_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_decode (
  input  wire  [31:0] inst,
  output logic [31:0] i_imm,
  output logic [31:0] s_imm,
  output logic [31:0] b_imm,
  output logic [31:0] u_imm,
  output logic [31:0] j_imm
);

  logic sign;

  assign sign = inst[31];

  assign i_imm = {{20{sign}}, inst[31:20]};

  assign s_imm = {{20{sign}}, inst[31:25], inst[11:7]};

  // Halfword aligned offset.
  assign b_imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  assign u_imm = {inst[31:12], 12'b0};

  assign j_imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

endmodule

`default_nettype wire

/* rtl/operand_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_fetch #(
  parameter int unsigned REG_COUNT = rv_pkg::REG_COUNT_DEFAULT
) (
  input  wire         clk,
  input  wire         arst_n,
  input  wire         issue_valid,
  input  wire  [31:0] issue_instruction,
  input  wire  [31:0] issue_pc,
  input  wire  [31:0] exec_result,
  input  wire         wr_we,
  input  wire  [4:0]  wr_addr,
  input  wire  [31:0] wr_data,
  exec_if.src         ex
);

  import rv_pkg::*;

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] rf_a;
  logic [31:0] rf_b;
  logic [4:0]  ex_rd;
  logic        ex_writes;
  logic [31:0] op_a_next;
  logic [31:0] op_b_next;

  assign rs1 = issue_instruction[19:15];
  assign rs2 = issue_instruction[24:20];

  reg_file #(
    .REG_COUNT(REG_COUNT)
  ) u_reg_file (
    .clk    (clk),
    .arst_n (arst_n),
    .raddr_a(rs1),
    .raddr_b(rs2),
    .rdata_a(rf_a),
    .rdata_b(rf_b),
    .we     (wr_we),
    .waddr  (wr_addr),
    .wdata  (wr_data)
  );

  // ########################################
  // Bypass from the exec stage
  // ########################################

  assign ex_rd = ex.instruction[11:7];

  always_comb begin
    case (opcode_e'(ex.instruction[6:0]))
      OPCODE_OP_IMM, OPCODE_OP, OPCODE_LUI, OPCODE_AUIPC, OPCODE_LOAD:
        ex_writes = ex.valid && (ex_rd != 5'd0);
      default:
        ex_writes = 1'b0;
    endcase
  end

  assign op_a_next = (ex_writes && (ex_rd == rs1)) ? exec_result : rf_a;
  assign op_b_next = (ex_writes && (ex_rd == rs2)) ? exec_result : rf_b;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      ex.instruction <= issue_instruction;
      ex.pc          <= issue_pc;
      ex.op_a        <= op_a_next;
      ex.op_b        <= op_b_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int unsigned REG_COUNT = rv_pkg::REG_COUNT_DEFAULT
) (
  input  wire         clk,
  input  wire         arst_n,
  input  wire  [4:0]  raddr_a,
  input  wire  [4:0]  raddr_b,
  output logic [31:0] rdata_a,
  output logic [31:0] rdata_b,
  input  wire         we,
  input  wire  [4:0]  waddr,
  input  wire  [31:0] wdata
);

  localparam int unsigned IDX_W = $clog2(REG_COUNT);

  logic [31:0]      regs [REG_COUNT];
  logic [IDX_W-1:0] ra_idx;
  logic [IDX_W-1:0] rb_idx;
  logic [IDX_W-1:0] wa_idx;

  // Upper address bits drop out for RV32E.
  assign ra_idx = raddr_a[IDX_W-1:0];
  assign rb_idx = raddr_b[IDX_W-1:0];
  assign wa_idx = waddr[IDX_W-1:0];

  assign rdata_a = (ra_idx == '0) ? 32'h0 : regs[ra_idx]; // x0 is zero.
  assign rdata_b = (rb_idx == '0) ? 32'h0 : regs[rb_idx];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (we && (wa_idx != '0)) begin
      regs[wa_idx] <= wdata;
    end
  end

endmodule

`default_nettype wire

/* rtl/result_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module result_commit (
  input  wire         clk,
  input  wire         arst_n,
  exec_if.dst         ex,
  input  wire  [31:0] result,
  output logic        wr_we,
  output logic [4:0]  wr_addr,
  output logic [31:0] wr_data,
  output logic        commit_valid,
  output logic [31:0] commit_pc,
  output logic        commit_illegal,
  output logic        rd_we,
  output logic [4:0]  rd_addr,
  output logic [31:0] rd_data,
  output logic        branch_taken,
  output logic [31:0] next_pc,
  output logic        mem_req,
  output logic        mem_we,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata
);

  import rv_pkg::*;

  logic [31:0] b_imm;
  logic [4:0]  rd;
  logic        writes_rd;
  logic        is_branch;
  logic        is_mem;
  logic        is_store;
  logic        illegal;
  logic        taken;
  logic [31:0] npc;

  imm_decode u_imm_decode (
    .inst (ex.instruction),
    .i_imm(),
    .s_imm(),
    .b_imm(b_imm),
    .u_imm(),
    .j_imm()
  );

  assign rd = ex.instruction[11:7];

  always_comb begin
    writes_rd = 1'b0;
    is_branch = 1'b0;
    is_mem    = 1'b0;
    is_store  = 1'b0;
    illegal   = 1'b0;
    case (opcode_e'(ex.instruction[6:0]))
      OPCODE_OP_IMM, OPCODE_OP, OPCODE_LUI, OPCODE_AUIPC: writes_rd = 1'b1;
      OPCODE_LOAD: begin
        writes_rd = 1'b1;
        is_mem    = 1'b1;
      end
      OPCODE_STORE: begin
        is_mem   = 1'b1;
        is_store = 1'b1;
      end
      OPCODE_BRANCH: is_branch = 1'b1;
      default:       illegal   = 1'b1;
    endcase
  end

  // Register file write lands with the commit edge.
  assign wr_we   = ex.valid && writes_rd && (rd != 5'd0);
  assign wr_addr = rd;
  assign wr_data = result;

  assign taken = is_branch && result[0];
  assign npc   = taken ? ex.pc + b_imm : ex.pc + 32'd4;

  // ########################################
  // Commit record
  // ########################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      commit_valid   <= 1'b0;
      commit_illegal <= 1'b0;
      rd_we          <= 1'b0;
      branch_taken   <= 1'b0;
      mem_req        <= 1'b0;
      mem_we         <= 1'b0;
    end else begin
      commit_valid   <= ex.valid;
      commit_illegal <= ex.valid && illegal;
      rd_we          <= wr_we;
      branch_taken   <= ex.valid && taken;
      mem_req        <= ex.valid && is_mem;
      mem_we         <= ex.valid && is_store;
    end
  end

  always_ff @(posedge clk) begin
    if (ex.valid) begin
      commit_pc <= ex.pc;
      rd_addr   <= rd;
      rd_data   <= result;
      next_pc   <= npc;
      mem_addr  <= result;
      mem_wdata <= ex.op_b; // rs2 after bypass.
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top #(
  parameter int unsigned REG_COUNT = rv_pkg::REG_COUNT_DEFAULT
) (
  input  wire         clk,
  input  wire         arst_n,
  input  wire         issue_valid,
  input  wire  [31:0] issue_instruction,
  input  wire  [31:0] issue_pc,
  output logic        commit_valid,
  output logic [31:0] commit_pc,
  output logic        commit_illegal,
  output logic        rd_we,
  output logic [4:0]  rd_addr,
  output logic [31:0] rd_data,
  output logic        branch_taken,
  output logic [31:0] next_pc,
  output logic        mem_req,
  output logic        mem_we,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata
);

  logic [31:0] exec_result;
  logic        wr_we;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;

  exec_if ex_bus ();

  operand_fetch #(
    .REG_COUNT(REG_COUNT)
  ) u_operand_fetch (
    .clk              (clk),
    .arst_n           (arst_n),
    .issue_valid      (issue_valid),
    .issue_instruction(issue_instruction),
    .issue_pc         (issue_pc),
    .exec_result      (exec_result),
    .wr_we            (wr_we),
    .wr_addr          (wr_addr),
    .wr_data          (wr_data),
    .ex               (ex_bus.src)
  );

  alu u_alu (
    .ex    (ex_bus.dst),
    .result(exec_result)
  );

  result_commit u_result_commit (
    .clk           (clk),
    .arst_n        (arst_n),
    .ex            (ex_bus.dst),
    .result        (exec_result),
    .wr_we         (wr_we),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .commit_valid  (commit_valid),
    .commit_pc     (commit_pc),
    .commit_illegal(commit_illegal),
    .rd_we         (rd_we),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .branch_taken  (branch_taken),
    .next_pc       (next_pc),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata)
  );

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // ########################################
  // Architectural sizes
  // ########################################

  localparam int unsigned REG_COUNT_DEFAULT = 32; // RV32I; use 16 for RV32E.

  // ########################################
  // Major opcodes
  // ########################################

  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_BRANCH = 7'b1100011
  } opcode_e;

  // ########################################
  // funct3 codes
  // ########################################

  // OP-IMM.
  localparam logic [2:0] FUNCT3_ADDI      = 3'b000;
  localparam logic [2:0] FUNCT3_SLLI      = 3'b001;
  localparam logic [2:0] FUNCT3_SLTI      = 3'b010;
  localparam logic [2:0] FUNCT3_SLTIU     = 3'b011;
  localparam logic [2:0] FUNCT3_XORI      = 3'b100;
  localparam logic [2:0] FUNCT3_SRLI_SRAI = 3'b101;
  localparam logic [2:0] FUNCT3_ORI       = 3'b110;
  localparam logic [2:0] FUNCT3_ANDI      = 3'b111;

  // OP.
  localparam logic [2:0] FUNCT3_ADD_SUB   = 3'b000;
  localparam logic [2:0] FUNCT3_SLL       = 3'b001;
  localparam logic [2:0] FUNCT3_SLT       = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU      = 3'b011;
  localparam logic [2:0] FUNCT3_XOR       = 3'b100;
  localparam logic [2:0] FUNCT3_SRL_SRA   = 3'b101;
  localparam logic [2:0] FUNCT3_OR        = 3'b110;
  localparam logic [2:0] FUNCT3_AND       = 3'b111;

  // BRANCH.
  localparam logic [2:0] FUNCT3_BEQ       = 3'b000;
  localparam logic [2:0] FUNCT3_BNE       = 3'b001;
  localparam logic [2:0] FUNCT3_BLT       = 3'b100;
  localparam logic [2:0] FUNCT3_BGE       = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU      = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU      = 3'b111;

endpackage

`default_nettype wire
